// ==== Bender.yml ====
package:
  name: pcie_config

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cfg_pkg.sv
      - source/cfg_decode.sv
      - source/cfg_execute.sv
      - source/cfg_result.sv
      - source/pcie_config_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verif/tb_pcie_config.sv

// ==== project.f ====
+incdir+source
source/cfg_pkg.sv
source/cfg_decode.sv
source/cfg_execute.sv
source/cfg_result.sv
source/pcie_config_top.sv
verif/tb_pcie_config.sv

// ==== source/cfg_consts.svh ====
`ifndef CFG_CONSTS_SVH
`define CFG_CONSTS_SVH

`define CFG_DATA_W      32
`define CFG_STRB_W      4
`define CFG_ADDR_W      32
`define CFG_DEC_W       16
`define CFG_PCIE_ADDR_W 64
`define CFG_RAM_ADDR_W  32
`define CFG_DMA_LEN_W   16
`define CFG_DMA_TAG_W   32

// Identification block
`define CFG_REG_FW_ID         16'h0000
`define CFG_REG_FW_VER        16'h0004
`define CFG_REG_BOARD_ID      16'h0008
`define CFG_REG_BOARD_VER     16'h000C
`define CFG_REG_PHC_COUNT     16'h0010
`define CFG_REG_PHC_OFFSET    16'h0014
`define CFG_REG_PHC_STRIDE    16'h0018
`define CFG_REG_IF_COUNT      16'h0020
`define CFG_REG_IF_STRIDE     16'h0024
`define CFG_REG_IF_CSR_OFFSET 16'h002C
`define CFG_REG_FPGA_ID       16'h0040

`define CFG_REG_GPIO_OUT 16'h0100
`define CFG_REG_GPIO_IN  16'h0104
`define CFG_REG_DMA_EN   16'h0400

`define CFG_REG_RD_PCIE_LO 16'h0440
`define CFG_REG_RD_PCIE_HI 16'h0444
`define CFG_REG_RD_RAM     16'h0448
`define CFG_REG_RD_LEN     16'h0450
`define CFG_REG_RD_TAG     16'h0454
`define CFG_REG_RD_STATUS  16'h0458
`define CFG_REG_WR_PCIE_LO 16'h0460
`define CFG_REG_WR_PCIE_HI 16'h0464
`define CFG_REG_WR_RAM     16'h0468
`define CFG_REG_WR_LEN     16'h0470
`define CFG_REG_WR_TAG     16'h0474
`define CFG_REG_WR_STATUS  16'h0478

`define CFG_FW_ID         32'h0000_0000
`define CFG_FW_VER        32'h0000_0001
`define CFG_BOARD_ID      32'h1ce4_0003
`define CFG_BOARD_VER     32'h0000_0001
`define CFG_FPGA_ID       32'h0382_3093
`define CFG_IF_COUNT      32'h0000_0002
`define CFG_IF_STRIDE     32'h8000_0000
`define CFG_IF_CSR_OFFSET 32'h0400_0000
`define CFG_PHC_COUNT     32'h0000_0000
`define CFG_PHC_OFFSET    32'h0000_0200
`define CFG_PHC_STRIDE    32'h0000_0080

// I2C line positions in the GPIO words
`define CFG_GPIO_SFP_SCL_BIT    16
`define CFG_GPIO_SFP1_SDA_BIT   17
`define CFG_GPIO_SFP2_SDA_BIT   18
`define CFG_GPIO_EEPROM_SCL_BIT 24
`define CFG_GPIO_EEPROM_SDA_BIT 25

`endif

// ==== source/cfg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_decode (
  input  wire                    pcie_clk,
  input  wire                    pcie_rst,
  input  wire [`CFG_ADDR_W-1:0]  awaddr_i,
  input  wire                    awvalid_i,
  input  wire [`CFG_DATA_W-1:0]  wdata_i,
  input  wire [`CFG_STRB_W-1:0]  wstrb_i,
  input  wire                    wvalid_i,
  input  wire                    bready_i,
  input  wire [`CFG_ADDR_W-1:0]  araddr_i,
  input  wire                    arvalid_i,
  input  wire                    rready_i,
  output logic                   awready_o,
  output logic                   wready_o,
  output logic                   bvalid_o,
  output logic                   arready_o,
  output logic                   rvalid_o,
  output cfg_pkg::cfg_wr_cmd_t   wr_cmd_o,
  output cfg_pkg::cfg_rd_cmd_t   rd_cmd_o
);
  import cfg_pkg::*;

  logic wr_accept;
  logic rd_accept;

  // Word address to opcode, unmapped words give OP_NONE
  function automatic cfg_op_e decode_addr(input logic [`CFG_ADDR_W-1:0] addr);
    logic [`CFG_DEC_W-1:0] offs;
    offs = {addr[15:2], 2'b00};
    case (offs)
      `CFG_REG_FW_ID:         return OP_FW_ID;
      `CFG_REG_FW_VER:        return OP_FW_VER;
      `CFG_REG_BOARD_ID:      return OP_BOARD_ID;
      `CFG_REG_BOARD_VER:     return OP_BOARD_VER;
      `CFG_REG_PHC_COUNT:     return OP_PHC_COUNT;
      `CFG_REG_PHC_OFFSET:    return OP_PHC_OFFSET;
      `CFG_REG_PHC_STRIDE:    return OP_PHC_STRIDE;
      `CFG_REG_IF_COUNT:      return OP_IF_COUNT;
      `CFG_REG_IF_STRIDE:     return OP_IF_STRIDE;
      `CFG_REG_IF_CSR_OFFSET: return OP_IF_CSR_OFFSET;
      `CFG_REG_FPGA_ID:       return OP_FPGA_ID;
      `CFG_REG_GPIO_OUT:      return OP_GPIO_OUT;
      `CFG_REG_GPIO_IN:       return OP_GPIO_IN;
      `CFG_REG_DMA_EN:        return OP_DMA_EN;
      `CFG_REG_RD_PCIE_LO:    return OP_RD_PCIE_LO;
      `CFG_REG_RD_PCIE_HI:    return OP_RD_PCIE_HI;
      `CFG_REG_RD_RAM:        return OP_RD_RAM;
      `CFG_REG_RD_LEN:        return OP_RD_LEN;
      `CFG_REG_RD_TAG:        return OP_RD_TAG;
      `CFG_REG_RD_STATUS:     return OP_RD_STATUS;
      `CFG_REG_WR_PCIE_LO:    return OP_WR_PCIE_LO;
      `CFG_REG_WR_PCIE_HI:    return OP_WR_PCIE_HI;
      `CFG_REG_WR_RAM:        return OP_WR_RAM;
      `CFG_REG_WR_LEN:        return OP_WR_LEN;
      `CFG_REG_WR_TAG:        return OP_WR_TAG;
      `CFG_REG_WR_STATUS:     return OP_WR_STATUS;
      default:                return OP_NONE;
    endcase
  endfunction

  assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;  // Both channels together
  assign rd_accept = arvalid_i && !rvalid_o;

  always_comb begin
    wr_cmd_o.valid = wr_accept;
    wr_cmd_o.op    = decode_addr(awaddr_i);
    wr_cmd_o.data  = wdata_i;
    wr_cmd_o.strb  = wstrb_i;
    rd_cmd_o.valid = rd_accept;
    rd_cmd_o.op    = decode_addr(araddr_i);
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      awready_o <= wr_accept;
      wready_o  <= wr_accept;
      bvalid_o  <= wr_accept || (bvalid_o && !bready_i);
      arready_o <= rd_accept;
      rvalid_o  <= rd_accept || (rvalid_o && !rready_i);
    end
  end

  // Responses are never withdrawn before the master takes them
  a_bvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o && !bready_i |=> bvalid_o);
  a_rvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rvalid_o && !rready_i |=> rvalid_o);

endmodule

`default_nettype wire

// ==== source/cfg_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_execute (
  input  wire                  pcie_clk,
  input  wire                  pcie_rst,
  input  cfg_pkg::cfg_wr_cmd_t wr_cmd_i,
  input  wire                  rd_desc_ready_i,
  input  wire                  wr_desc_ready_i,
  output cfg_pkg::cfg_state_t  state_o,
  output cfg_pkg::gpio_pins_t  gpio_out_o,
  output cfg_pkg::dma_desc_t   rd_desc_o,
  output cfg_pkg::dma_desc_t   wr_desc_o,
  output logic                 rd_desc_valid_o,
  output logic                 wr_desc_valid_o
);
  import cfg_pkg::*;

  gpio_pins_t gpio_q;
  logic       dma_en_q;
  dma_desc_t  desc_q [2];    // 0 is host read, 1 is host write
  logic [1:0] desc_vld_q;
  logic [1:0] desc_rdy;

  assign desc_rdy = {wr_desc_ready_i, rd_desc_ready_i};

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      gpio_q   <= '1;  // Released I2C lines
      dma_en_q <= 1'b1;
    end else if (wr_cmd_i.valid) begin
      case (wr_cmd_i.op)
        OP_GPIO_OUT: begin
          // SFP lines live in byte 2
          if (wr_cmd_i.strb[2]) begin
            gpio_q.sfp_scl  <= wr_cmd_i.data[`CFG_GPIO_SFP_SCL_BIT];
            gpio_q.sfp1_sda <= wr_cmd_i.data[`CFG_GPIO_SFP1_SDA_BIT];
            gpio_q.sfp2_sda <= wr_cmd_i.data[`CFG_GPIO_SFP2_SDA_BIT];
          end
          if (wr_cmd_i.strb[3]) begin
            gpio_q.eeprom_scl <= wr_cmd_i.data[`CFG_GPIO_EEPROM_SCL_BIT];
            gpio_q.eeprom_sda <= wr_cmd_i.data[`CFG_GPIO_EEPROM_SDA_BIT];
          end
        end
        OP_DMA_EN: dma_en_q <= wr_cmd_i.data[0];
        default: ;
      endcase
    end
  end

  // Extra flop between register and pads
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      gpio_out_o <= '1;
    end else begin
      gpio_out_o <= gpio_q;
    end
  end

  for (genvar d = 0; d < 2; d++) begin : g_dir
    localparam logic [5:0] op_lo  = (d == 0) ? OP_RD_PCIE_LO : OP_WR_PCIE_LO;
    localparam logic [5:0] op_hi  = (d == 0) ? OP_RD_PCIE_HI : OP_WR_PCIE_HI;
    localparam logic [5:0] op_ram = (d == 0) ? OP_RD_RAM : OP_WR_RAM;
    localparam logic [5:0] op_len = (d == 0) ? OP_RD_LEN : OP_WR_LEN;
    localparam logic [5:0] op_tag = (d == 0) ? OP_RD_TAG : OP_WR_TAG;

    logic tag_wr;

    assign tag_wr = wr_cmd_i.valid && (wr_cmd_i.op == op_tag);

    always_ff @(posedge pcie_clk) begin
      if (wr_cmd_i.valid) begin
        case (wr_cmd_i.op)
          op_lo:  desc_q[d].pcie_addr[31:0]  <= wr_cmd_i.data;
          op_hi:  desc_q[d].pcie_addr[63:32] <= wr_cmd_i.data;
          op_ram: desc_q[d].ram_addr         <= wr_cmd_i.data;
          op_len: desc_q[d].len              <= wr_cmd_i.data[`CFG_DMA_LEN_W-1:0];
          op_tag: desc_q[d].tag              <= wr_cmd_i.data;
          default: ;
        endcase
      end
    end

    // New tag wins over a ready in the same cycle
    always_ff @(posedge pcie_clk) begin
      if (pcie_rst) begin
        desc_vld_q[d] <= 1'b0;
      end else if (tag_wr) begin
        desc_vld_q[d] <= 1'b1;
      end else if (desc_rdy[d]) begin
        desc_vld_q[d] <= 1'b0;
      end
    end

    a_desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
      desc_vld_q[d] && !desc_rdy[d] |=> desc_vld_q[d]);
  end

  assign rd_desc_o        = desc_q[0];
  assign wr_desc_o        = desc_q[1];
  assign rd_desc_valid_o  = desc_vld_q[0];
  assign wr_desc_valid_o  = desc_vld_q[1];
  assign state_o.gpio_out   = gpio_q;
  assign state_o.dma_enable = dma_en_q;

endmodule

`default_nettype wire

// ==== source/cfg_pkg.sv ====
`default_nettype none

`include "cfg_consts.svh"

package cfg_pkg;

  // One opcode per decoded register
  typedef enum logic [5:0] {
    OP_NONE,
    OP_FW_ID, OP_FW_VER, OP_BOARD_ID, OP_BOARD_VER,
    OP_PHC_COUNT, OP_PHC_OFFSET, OP_PHC_STRIDE,
    OP_IF_COUNT, OP_IF_STRIDE, OP_IF_CSR_OFFSET, OP_FPGA_ID,
    OP_GPIO_OUT, OP_GPIO_IN, OP_DMA_EN,
    OP_RD_PCIE_LO, OP_RD_PCIE_HI, OP_RD_RAM, OP_RD_LEN, OP_RD_TAG, OP_RD_STATUS,
    OP_WR_PCIE_LO, OP_WR_PCIE_HI, OP_WR_RAM, OP_WR_LEN, OP_WR_TAG, OP_WR_STATUS
  } cfg_op_e;

  typedef struct packed {
    logic                   valid;  // Single-cycle strobe
    cfg_op_e                op;
    logic [`CFG_DATA_W-1:0] data;
    logic [`CFG_STRB_W-1:0] strb;
  } cfg_wr_cmd_t;

  typedef struct packed {
    logic    valid;
    cfg_op_e op;
  } cfg_rd_cmd_t;

  typedef struct packed {
    logic sfp_scl;
    logic sfp1_sda;
    logic sfp2_sda;
    logic eeprom_scl;
    logic eeprom_sda;
  } gpio_pins_t;

  typedef struct packed {
    logic [`CFG_PCIE_ADDR_W-1:0] pcie_addr;
    logic [`CFG_RAM_ADDR_W-1:0]  ram_addr;
    logic [`CFG_DMA_LEN_W-1:0]   len;
    logic [`CFG_DMA_TAG_W-1:0]   tag;
  } dma_desc_t;

  typedef struct packed {
    logic                      valid;
    logic [`CFG_DMA_TAG_W-1:0] tag;
  } dma_status_t;

  typedef struct packed {
    gpio_pins_t gpio_out;   // Register value, before the pin stage
    logic       dma_enable;
  } cfg_state_t;

endpackage

`default_nettype wire

// ==== source/cfg_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_result (
  input  wire                    pcie_clk,
  input  wire                    pcie_rst,
  input  cfg_pkg::cfg_rd_cmd_t   rd_cmd_i,
  input  cfg_pkg::cfg_state_t    state_i,
  input  cfg_pkg::gpio_pins_t    gpio_in_i,
  input  cfg_pkg::dma_status_t   rd_status_i,
  input  cfg_pkg::dma_status_t   wr_status_i,
  output logic [`CFG_DATA_W-1:0] rdata_o
);
  import cfg_pkg::*;

  gpio_pins_t                gpio_in_q;
  dma_status_t               status_in [2];
  logic [`CFG_DMA_TAG_W-1:0] tags_q [2];
  logic [`CFG_DATA_W-1:0]    rdata_d;

  // Places the five I2C lines at their register bit positions
  function automatic logic [`CFG_DATA_W-1:0] gpio_word(input gpio_pins_t p);
    logic [`CFG_DATA_W-1:0] w;
    w = '0;
    w[`CFG_GPIO_SFP_SCL_BIT]    = p.sfp_scl;
    w[`CFG_GPIO_SFP1_SDA_BIT]   = p.sfp1_sda;
    w[`CFG_GPIO_SFP2_SDA_BIT]   = p.sfp2_sda;
    w[`CFG_GPIO_EEPROM_SCL_BIT] = p.eeprom_scl;
    w[`CFG_GPIO_EEPROM_SDA_BIT] = p.eeprom_sda;
    return w;
  endfunction

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      gpio_in_q <= '1;
    end else begin
      gpio_in_q <= gpio_in_i;
    end
  end

  assign status_in[0] = rd_status_i;
  assign status_in[1] = wr_status_i;

  for (genvar d = 0; d < 2; d++) begin : g_tags
    localparam logic [5:0] op_status = (d == 0) ? OP_RD_STATUS : OP_WR_STATUS;

    always_ff @(posedge pcie_clk) begin
      if (pcie_rst) begin
        tags_q[d] <= '0;
      end else if (rd_cmd_i.valid && (rd_cmd_i.op == op_status)) begin
        // Clear on read, keep a tag landing in the same cycle
        tags_q[d] <= status_in[d].valid ? status_in[d].tag : '0;
      end else if (status_in[d].valid) begin
        tags_q[d] <= tags_q[d] | status_in[d].tag;
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    case (rd_cmd_i.op)
      OP_FW_ID:         rdata_d = `CFG_FW_ID;
      OP_FW_VER:        rdata_d = `CFG_FW_VER;
      OP_BOARD_ID:      rdata_d = `CFG_BOARD_ID;
      OP_BOARD_VER:     rdata_d = `CFG_BOARD_VER;
      OP_PHC_COUNT:     rdata_d = `CFG_PHC_COUNT;
      OP_PHC_OFFSET:    rdata_d = `CFG_PHC_OFFSET;
      OP_PHC_STRIDE:    rdata_d = `CFG_PHC_STRIDE;
      OP_IF_COUNT:      rdata_d = `CFG_IF_COUNT;
      OP_IF_STRIDE:     rdata_d = `CFG_IF_STRIDE;
      OP_IF_CSR_OFFSET: rdata_d = `CFG_IF_CSR_OFFSET;
      OP_FPGA_ID:       rdata_d = `CFG_FPGA_ID;
      OP_GPIO_OUT:      rdata_d = gpio_word(state_i.gpio_out);
      OP_GPIO_IN:       rdata_d = gpio_word(gpio_in_q);
      OP_DMA_EN:        rdata_d = {{(`CFG_DATA_W-1){1'b0}}, state_i.dma_enable};
      OP_RD_STATUS:     rdata_d = tags_q[0];
      OP_WR_STATUS:     rdata_d = tags_q[1];
      default:          rdata_d = '0;  // Descriptor fields are write-only
    endcase
  end

  // Held while rvalid waits
  always_ff @(posedge pcie_clk) begin
    if (rd_cmd_i.valid) begin
      rdata_o <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/pcie_config_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module pcie_config_top (
  input  wire                    pcie_clk,
  input  wire                    pcie_rst,
  input  wire [`CFG_ADDR_W-1:0]  awaddr_i,
  input  wire                    awvalid_i,
  output logic                   awready_o,
  input  wire [`CFG_DATA_W-1:0]  wdata_i,
  input  wire [`CFG_STRB_W-1:0]  wstrb_i,
  input  wire                    wvalid_i,
  output logic                   wready_o,
  output logic [1:0]             bresp_o,
  output logic                   bvalid_o,
  input  wire                    bready_i,
  input  wire [`CFG_ADDR_W-1:0]  araddr_i,
  input  wire                    arvalid_i,
  output logic                   arready_o,
  output logic [`CFG_DATA_W-1:0] rdata_o,
  output logic [1:0]             rresp_o,
  output logic                   rvalid_o,
  input  wire                    rready_i,
  output cfg_pkg::dma_desc_t     rd_desc_o,
  output logic                   rd_desc_valid_o,
  input  wire                    rd_desc_ready_i,
  input  cfg_pkg::dma_status_t   rd_status_i,
  output cfg_pkg::dma_desc_t     wr_desc_o,
  output logic                   wr_desc_valid_o,
  input  wire                    wr_desc_ready_i,
  input  cfg_pkg::dma_status_t   wr_status_i,
  input  cfg_pkg::gpio_pins_t    gpio_in_i,
  output cfg_pkg::gpio_pins_t    gpio_out_o,
  output cfg_pkg::gpio_pins_t    gpio_oe_o,
  output logic                   dma_enable_o
);
  import cfg_pkg::*;

  cfg_wr_cmd_t wr_cmd;
  cfg_rd_cmd_t rd_cmd;
  cfg_state_t  state;

  assign bresp_o      = 2'b00;  // Always OKAY
  assign rresp_o      = 2'b00;
  assign gpio_oe_o    = gpio_out_o;  // Open drain, drive low only
  assign dma_enable_o = state.dma_enable;

  cfg_decode u_decode (
    .pcie_clk  (pcie_clk),
    .pcie_rst  (pcie_rst),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .rready_i  (rready_i),
    .awready_o (awready_o),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .arready_o (arready_o),
    .rvalid_o  (rvalid_o),
    .wr_cmd_o  (wr_cmd),
    .rd_cmd_o  (rd_cmd)
  );

  cfg_execute u_execute (
    .pcie_clk        (pcie_clk),
    .pcie_rst        (pcie_rst),
    .wr_cmd_i        (wr_cmd),
    .rd_desc_ready_i (rd_desc_ready_i),
    .wr_desc_ready_i (wr_desc_ready_i),
    .state_o         (state),
    .gpio_out_o      (gpio_out_o),
    .rd_desc_o       (rd_desc_o),
    .wr_desc_o       (wr_desc_o),
    .rd_desc_valid_o (rd_desc_valid_o),
    .wr_desc_valid_o (wr_desc_valid_o)
  );

  cfg_result u_result (
    .pcie_clk    (pcie_clk),
    .pcie_rst    (pcie_rst),
    .rd_cmd_i    (rd_cmd),
    .state_i     (state),
    .gpio_in_i   (gpio_in_i),
    .rd_status_i (rd_status_i),
    .wr_status_i (wr_status_i),
    .rdata_o     (rdata_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_pcie_config.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module tb_pcie_config;
  import cfg_pkg::*;

  localparam int clk_period = 20;
  localparam int test_count = 6;

  logic pcie_clk;
  logic pcie_rst;
  logic [`CFG_ADDR_W-1:0] awaddr, araddr;
  logic [`CFG_DATA_W-1:0] wdata, rdata_o;
  logic [`CFG_STRB_W-1:0] wstrb;
  logic awvalid, wvalid, bready, arvalid, rready;
  logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [1:0] bresp_o, rresp_o;
  logic [1:0] desc_ready;  // Bit 0 host read, bit 1 host write
  dma_desc_t rd_desc_o, wr_desc_o;
  logic rd_desc_valid_o, wr_desc_valid_o, dma_enable_o;
  dma_status_t rd_status, wr_status;
  gpio_pins_t gpio_in, gpio_out_o, gpio_oe_o;

  // Reference model and bookkeeping
  logic [31:0] exp_rdata;
  gpio_pins_t exp_gpio;
  logic exp_dma_en;
  dma_desc_t exp_desc [2];
  logic [31:0] rng;
  int errors;
  int errs_start;
  int tests_run;

  logic wr_acc;
  logic rd_acc;
  logic [1:0] desc_vld;
  logic [1:0] tag_acc;
  dma_desc_t desc_out [2];

  assign wr_acc = awvalid && wvalid && !bvalid_o;
  assign rd_acc = arvalid && !rvalid_o;
  assign desc_vld = {wr_desc_valid_o, rd_desc_valid_o};
  assign desc_out[0] = rd_desc_o;
  assign desc_out[1] = wr_desc_o;
  assign tag_acc[0] = wr_acc && (awaddr[15:0] == `CFG_REG_RD_TAG);
  assign tag_acc[1] = wr_acc && (awaddr[15:0] == `CFG_REG_WR_TAG);

  pcie_config_top dut0 (
    .pcie_clk (pcie_clk), .pcie_rst (pcie_rst),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready_o),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready_o),
    .bresp_o (bresp_o), .bvalid_o (bvalid_o), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready_o),
    .rdata_o (rdata_o), .rresp_o (rresp_o), .rvalid_o (rvalid_o), .rready_i (rready),
    .rd_desc_o (rd_desc_o), .rd_desc_valid_o (rd_desc_valid_o),
    .rd_desc_ready_i (desc_ready[0]), .rd_status_i (rd_status),
    .wr_desc_o (wr_desc_o), .wr_desc_valid_o (wr_desc_valid_o),
    .wr_desc_ready_i (desc_ready[1]), .wr_status_i (wr_status),
    .gpio_in_i (gpio_in), .gpio_out_o (gpio_out_o), .gpio_oe_o (gpio_oe_o),
    .dma_enable_o (dma_enable_o)
  );

  always #(clk_period / 2) pcie_clk = ~pcie_clk;

  a_reset_state: assert property (@(posedge pcie_clk) $fell(pcie_rst) |->
    !awready_o && !wready_o && !bvalid_o && !arready_o && !rvalid_o &&
    !rd_desc_valid_o && !wr_desc_valid_o && gpio_out_o == '1 && dma_enable_o)
    else begin
      $display("[%0t] outputs are not at their reset values after reset", $time);
      errors++;
    end

  a_rdata: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rvalid_o && rready |-> rdata_o == exp_rdata)
    else begin
      $display("FAIL t=%0t rdata_o expected %h got %h", $time, $sampled(exp_rdata),
        $sampled(rdata_o));
      errors++;
    end

  a_resp_okay: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o || rvalid_o |-> bresp_o == 2'b00 && rresp_o == 2'b00)
    else begin
      $display("FAIL t=%0t bresp_o/rresp_o expected 0/0 got %0d/%0d", $time,
        $sampled(bresp_o), $sampled(rresp_o));
      errors++;
    end

  // Ready strobes last exactly one cycle after an accept
  a_wr_ready: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr_acc |=> awready_o && wready_o && bvalid_o)
    else begin
      $display("FAIL t=%0t awready_o/wready_o/bvalid_o expected 1/1/1 got %b/%b/%b",
        $time, $sampled(awready_o), $sampled(wready_o), $sampled(bvalid_o));
      errors++;
    end

  a_wr_ready_end: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr_acc |=> ##1 !awready_o && !wready_o)
    else begin
      $display("FAIL t=%0t awready_o/wready_o expected 0/0 got %b/%b", $time,
        $sampled(awready_o), $sampled(wready_o));
      errors++;
    end

  a_rd_ready: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rd_acc |=> arready_o && rvalid_o)
    else begin
      $display("FAIL t=%0t arready_o/rvalid_o expected 1/1 got %b/%b", $time,
        $sampled(arready_o), $sampled(rvalid_o));
      errors++;
    end

  a_rd_ready_end: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rd_acc |=> ##1 !arready_o)
    else begin
      $display("FAIL t=%0t arready_o expected 0 got %b", $time, $sampled(arready_o));
      errors++;
    end

  // Pins follow one cycle after the register
  a_gpio_pins: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr_acc && awaddr[15:0] == `CFG_REG_GPIO_OUT |=> ##1
    gpio_out_o == exp_gpio && gpio_oe_o == exp_gpio)
    else begin
      $display("FAIL t=%0t gpio_out_o/gpio_oe_o expected %b got %b/%b", $time,
        $sampled(exp_gpio), $sampled(gpio_out_o), $sampled(gpio_oe_o));
      errors++;
    end

  a_dma_en: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr_acc && awaddr[15:0] == `CFG_REG_DMA_EN |=> dma_enable_o == exp_dma_en)
    else begin
      $display("FAIL t=%0t dma_enable_o expected %b got %b", $time, $sampled(exp_dma_en),
        $sampled(dma_enable_o));
      errors++;
    end

  a_bresp_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o && !bready |=> bvalid_o && $stable(dma_enable_o))
    else begin
      $display("[%0t] bvalid_o dropped or a write landed while bready was low", $time);
      errors++;
    end

  for (genvar d = 0; d < 2; d++) begin : g_desc_chk
    a_desc_issue: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
      tag_acc[d] |=> desc_vld[d] && desc_out[d] == exp_desc[d])
      else begin
        $display("FAIL t=%0t %s expected %h valid 1 got %h valid %b", $time,
          d ? "wr_desc_o" : "rd_desc_o", $sampled(exp_desc[d]), $sampled(desc_out[d]),
          $sampled(desc_vld[d]));
        errors++;
      end
    a_desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
      desc_vld[d] && !desc_ready[d] |=> desc_vld[d])
      else begin
        $display("[%0t] descriptor %0d valid fell without ready", $time, d);
        errors++;
      end
    a_desc_done: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
      desc_vld[d] && desc_ready[d] && !tag_acc[d] |=> !desc_vld[d])
      else begin
        $display("[%0t] descriptor %0d valid stayed high after ready", $time, d);
        errors++;
      end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] pins_to_word(input gpio_pins_t p);
    logic [31:0] w;
    w = '0;
    w[`CFG_GPIO_SFP_SCL_BIT]    = p.sfp_scl;
    w[`CFG_GPIO_SFP1_SDA_BIT]   = p.sfp1_sda;
    w[`CFG_GPIO_SFP2_SDA_BIT]   = p.sfp2_sda;
    w[`CFG_GPIO_EEPROM_SCL_BIT] = p.eeprom_scl;
    w[`CFG_GPIO_EEPROM_SDA_BIT] = p.eeprom_sda;
    return w;
  endfunction

  task automatic update_model(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    case (addr)
      `CFG_REG_GPIO_OUT: begin
        if (strb[2]) begin
          exp_gpio.sfp_scl  <= data[`CFG_GPIO_SFP_SCL_BIT];
          exp_gpio.sfp1_sda <= data[`CFG_GPIO_SFP1_SDA_BIT];
          exp_gpio.sfp2_sda <= data[`CFG_GPIO_SFP2_SDA_BIT];
        end
        if (strb[3]) begin
          exp_gpio.eeprom_scl <= data[`CFG_GPIO_EEPROM_SCL_BIT];
          exp_gpio.eeprom_sda <= data[`CFG_GPIO_EEPROM_SDA_BIT];
        end
      end
      `CFG_REG_DMA_EN:     exp_dma_en <= data[0];
      `CFG_REG_RD_PCIE_LO: exp_desc[0].pcie_addr[31:0] <= data;
      `CFG_REG_RD_PCIE_HI: exp_desc[0].pcie_addr[63:32] <= data;
      `CFG_REG_RD_RAM:     exp_desc[0].ram_addr <= data;
      `CFG_REG_RD_LEN:     exp_desc[0].len <= data[`CFG_DMA_LEN_W-1:0];
      `CFG_REG_RD_TAG:     exp_desc[0].tag <= data;
      `CFG_REG_WR_PCIE_LO: exp_desc[1].pcie_addr[31:0] <= data;
      `CFG_REG_WR_PCIE_HI: exp_desc[1].pcie_addr[63:32] <= data;
      `CFG_REG_WR_RAM:     exp_desc[1].ram_addr <= data;
      `CFG_REG_WR_LEN:     exp_desc[1].len <= data[`CFG_DMA_LEN_W-1:0];
      `CFG_REG_WR_TAG:     exp_desc[1].tag <= data;
      default: ;
    endcase
  endtask

  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int n;
    n = 0;
    @(posedge pcie_clk);
    awaddr  <= {16'h0, addr};
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    update_model(addr, data, strb);
    do begin
      @(negedge pcie_clk);
      n++;
    end while (!awready_o && n < 50);
    if (!awready_o) begin
      $display("[%0t] write to %h was never accepted", $time, addr);
      errors++;
    end
    @(posedge pcie_clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, input logic [31:0] expected);
    int n;
    n = 0;
    @(posedge pcie_clk);
    araddr    <= {16'h0, addr};
    arvalid   <= 1'b1;
    exp_rdata <= expected;
    do begin
      @(negedge pcie_clk);
      n++;
    end while (!arready_o && n < 50);
    if (!arready_o) begin
      $display("[%0t] read of %h was never accepted", $time, addr);
      errors++;
    end
    @(posedge pcie_clk);
    arvalid <= 1'b0;
  endtask

  task automatic drive_status(input int d, input logic v, input logic [31:0] t);
    if (d == 0) begin
      rd_status <= {v, t};
    end else begin
      wr_status <= {v, t};
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("[%0t] test %0d %s finished, %0d errors", $time, tests_run, name,
      errors - errs_start);
    errs_start = errors;
  endtask

  task automatic test_ids();
    axil_read(`CFG_REG_FW_ID, `CFG_FW_ID);
    axil_read(`CFG_REG_FW_VER, `CFG_FW_VER);
    axil_read(`CFG_REG_BOARD_ID, `CFG_BOARD_ID);
    axil_read(`CFG_REG_BOARD_VER, `CFG_BOARD_VER);
    axil_read(`CFG_REG_PHC_COUNT, `CFG_PHC_COUNT);
    axil_read(`CFG_REG_PHC_OFFSET, `CFG_PHC_OFFSET);
    axil_read(`CFG_REG_PHC_STRIDE, `CFG_PHC_STRIDE);
    axil_read(`CFG_REG_IF_COUNT, `CFG_IF_COUNT);
    axil_read(`CFG_REG_IF_STRIDE, `CFG_IF_STRIDE);
    axil_read(`CFG_REG_IF_CSR_OFFSET, `CFG_IF_CSR_OFFSET);
    axil_read(`CFG_REG_FPGA_ID, `CFG_FPGA_ID);
    axil_read(16'h0200, 32'h0);  // Hole in the map
  endtask

  task automatic test_gpio_out();
    logic [31:0] data;
    axil_write(`CFG_REG_GPIO_OUT, 32'h0, 4'b0100);
    axil_read(`CFG_REG_GPIO_OUT, pins_to_word(exp_gpio));
    axil_write(`CFG_REG_GPIO_OUT, 32'h0, 4'b1000);
    axil_read(`CFG_REG_GPIO_OUT, pins_to_word(exp_gpio));
    for (int i = 0; i < 6; i++) begin
      rng = xorshift32(rng);
      data = rng;
      rng = xorshift32(rng);
      axil_write(`CFG_REG_GPIO_OUT, data, rng[3:0]);
      axil_read(`CFG_REG_GPIO_OUT, pins_to_word(exp_gpio));
    end
  endtask

  task automatic test_gpio_in();
    gpio_pins_t p;
    for (int i = 0; i < 5; i++) begin
      rng = xorshift32(rng);
      p = rng[4:0];
      @(posedge pcie_clk);
      gpio_in <= p;
      repeat (3) @(posedge pcie_clk);
      axil_read(`CFG_REG_GPIO_IN, pins_to_word(p));
    end
  endtask

  task automatic test_desc(input int d);
    logic [15:0] base;
    logic [31:0] w [5];
    int n;
    base = d ? `CFG_REG_WR_PCIE_LO : `CFG_REG_RD_PCIE_LO;
    for (int i = 0; i < 5; i++) begin
      rng = xorshift32(rng);
      w[i] = rng;
    end
    // Field offsets are the same in both descriptor blocks
    axil_write(base, w[0], 4'hf);
    axil_write(base + 16'h04, w[1], 4'hf);
    axil_write(base + 16'h08, w[2], 4'hf);
    axil_write(base + 16'h10, w[3], 4'hf);
    axil_write(base + 16'h14, w[4], 4'hf);
    n = 0;
    while (desc_vld[d] && n < 100) begin
      @(posedge pcie_clk);
      rng = xorshift32(rng);
      desc_ready[d] <= rng[0] & rng[7];
      @(negedge pcie_clk);
      n++;
    end
    if (desc_vld[d]) begin
      $display("[%0t] descriptor %0d was never taken", $time, d);
      errors++;
    end
    @(posedge pcie_clk);
    desc_ready[d] <= 1'b0;
  endtask

  task automatic test_tags(input int d);
    logic [15:0] addr;
    logic [31:0] acc;
    logic [31:0] late;
    addr = d ? `CFG_REG_WR_STATUS : `CFG_REG_RD_STATUS;
    acc = '0;
    for (int i = 0; i < 5; i++) begin
      rng = xorshift32(rng);
      @(posedge pcie_clk);
      drive_status(d, 1'b1, 32'h1 << rng[4:0]);
      acc = acc | (32'h1 << rng[4:0]);
      @(posedge pcie_clk);
      drive_status(d, 1'b0, 32'h0);
    end
    rng = xorshift32(rng);
    late = 32'h1 << rng[4:0];
    fork
      axil_read(addr, acc);
      begin
        @(posedge pcie_clk);  // Lands in the read's accept cycle
        drive_status(d, 1'b1, late);
        @(posedge pcie_clk);
        drive_status(d, 1'b0, 32'h0);
      end
    join
    axil_read(addr, late);
    axil_read(addr, 32'h0);
  endtask

  task automatic test_backpressure();
    @(posedge pcie_clk);
    bready <= 1'b0;
    axil_write(`CFG_REG_DMA_EN, 32'h0, 4'hf);
    axil_read(`CFG_REG_DMA_EN, 32'h0);
    fork
      axil_write(`CFG_REG_DMA_EN, 32'h1, 4'hf);
      begin
        repeat (6) @(posedge pcie_clk);
        bready <= 1'b1;
      end
    join
    axil_read(`CFG_REG_DMA_EN, 32'h1);
  endtask

  initial begin
    pcie_clk   = 1'b0;
    pcie_rst   = 1'b1;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b1;
    desc_ready = 2'b00;
    rd_status  = '0;
    wr_status  = '0;
    gpio_in    = '1;
    exp_rdata  = '0;
    exp_gpio   = '1;
    exp_dma_en = 1'b1;
    rng        = 32'hd3f6;
    errors     = 0;
    errs_start = 0;
    tests_run  = 0;
    repeat (2) @(posedge pcie_clk);
    pcie_rst <= 1'b0;
    test_ids();
    finish_test("reset and identification");
    test_gpio_out();
    finish_test("gpio output");
    test_gpio_in();
    finish_test("gpio input");
    test_desc(0);
    test_desc(1);
    finish_test("descriptor issue");
    test_tags(0);
    test_tags(1);
    finish_test("tag accumulation");
    test_backpressure();
    finish_test("dma enable and back-pressure");
    repeat (4) @(posedge pcie_clk);
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(test_count * 400 * clk_period);
    $display("watchdog expired after %0d cycles, run stopped", test_count * 400);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
